/* include/rx_dsp_macros.svh */
`ifndef RX_DSP_MACROS_SVH
`define RX_DSP_MACROS_SVH

// datapath dimensions
`define RX_NTI 16
`define RX_NADC 8
`define RX_NCNT 32

// self-synchronizing checker polynomial x^7 + x^6 + 1
`define RX_PRBS_ORDER 7

// wishbone bus widths
`define RX_WB_AW 3
`define RX_WB_DW 32

// register word addresses
`define RX_ADDR_CTRL 3'd0
`define RX_ADDR_OFFSET 3'd1
`define RX_ADDR_THRESH 3'd2
`define RX_ADDR_ERRCNT 3'd3
`define RX_ADDR_TOTCNT 3'd4

`endif

/* project.f */
+incdir+include
src/rx_dsp_pkg.sv
src/adc_unfold_stage.sv
src/slicer_stage.sv
src/prbs_check_stage.sv
src/rx_csr_wb.sv
src/rx_digital_core.sv
tests/rx_digital_core_chk.sv
tests/tb_rx_digital_core.sv

/* src/adc_unfold_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_dsp_macros.svh"

module adc_unfold_stage import rx_dsp_pkg::*; (
    input  wire logic         clk_adc_i,
    input  wire logic         arst_n_i,
    input  wire adc_word_t    adc_i,
    input  wire logic         adc_valid_i,
    input  wire rx_cfg_t      cfg_i,
    output sample_word_t      sample_o
);

    localparam int SMP_MAX = 2**(`RX_NADC-1) - 1;
    localparam int SMP_MIN = -(2**(`RX_NADC-1));

    // two extra bits hold the full +/-255 difference
    logic signed [`RX_NADC+1:0] diff [`RX_NTI];
    sample_t [`RX_NTI-1:0]      sat;
    sample_t [`RX_NTI-1:0]      smp_q;
    logic                       valid_q;

    always_comb begin
        for (int i = 0; i < `RX_NTI; i++) begin
            if (adc_i.sign[i]) begin
                diff[i] = $signed({2'b00, adc_i.mag[i]}) - $signed({2'b00, cfg_i.pfd_offset});
            end else begin
                diff[i] = $signed({2'b00, cfg_i.pfd_offset}) - $signed({2'b00, adc_i.mag[i]});
            end
            if (diff[i] > SMP_MAX) begin
                sat[i] = sample_t'(SMP_MAX);
            end else if (diff[i] < SMP_MIN) begin
                sat[i] = sample_t'(SMP_MIN);
            end else begin
                sat[i] = sample_t'(diff[i]);
            end
        end
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= adc_valid_i;
        end
    end

    // samples only load on valid words
    always_ff @(posedge clk_adc_i) begin
        if (adc_valid_i) begin
            smp_q <= sat;
        end
    end

    assign sample_o = '{valid: valid_q, smp: smp_q};

endmodule

`default_nettype wire

/* src/prbs_check_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_dsp_macros.svh"

module prbs_check_stage import rx_dsp_pkg::*; (
    input  wire logic      clk_adc_i,
    input  wire logic      arst_n_i,
    input  wire bit_word_t bits_i,
    input  wire rx_cfg_t   cfg_i,
    output prbs_count_t    count_o
);

    localparam int ORD = `RX_PRBS_ORDER;

    // hist_q[0] is the oldest stored bit and sits ORD positions before bits_i.bits[0]
    logic [ORD-1:0]              hist_q;
    logic [`RX_NTI+ORD-1:0]      ext;
    logic [`RX_NTI-1:0]          err_vec;
    logic [$clog2(`RX_NTI):0]    err_num;
    logic                        primed_q;
    logic [`RX_NCNT-1:0]         err_cnt_q;
    logic [`RX_NCNT-1:0]         tot_cnt_q;

    assign ext = {bits_i.bits, hist_q};

    // each bit should equal the xor of the bits 7 and 6 positions back
    always_comb begin
        err_num = '0;
        for (int i = 0; i < `RX_NTI; i++) begin
            err_vec[i] = ext[i+ORD] ^ ext[i] ^ ext[i+1];
            err_num    = err_num + err_vec[i];
        end
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            primed_q  <= 1'b0;
            err_cnt_q <= '0;
            tot_cnt_q <= '0;
        end else if (cfg_i.cnt_clr) begin
            primed_q  <= 1'b0;
            err_cnt_q <= '0;
            tot_cnt_q <= '0;
        end else if (bits_i.valid) begin
            if (!primed_q) begin
                // first word only fills the history
                primed_q <= 1'b1;
            end else if (cfg_i.prbs_en) begin
                err_cnt_q <= err_cnt_q + `RX_NCNT'(err_num);
                tot_cnt_q <= tot_cnt_q + `RX_NCNT'(`RX_NTI);
            end
        end
    end

    // history tracks the stream whether or not counting is on
    always_ff @(posedge clk_adc_i) begin
        if (bits_i.valid) begin
            hist_q <= ext[`RX_NTI+ORD-1:`RX_NTI];
        end
    end

    assign count_o = '{err_count: err_cnt_q, total_count: tot_cnt_q};

endmodule

`default_nettype wire

/* src/rx_csr_wb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_dsp_macros.svh"

module rx_csr_wb import rx_dsp_pkg::*; (
    input  wire logic        clk_adc_i,
    input  wire logic        arst_n_i,
    input  wire wb_req_t     wb_req_i,
    output wb_rsp_t          wb_rsp_o,
    input  wire prbs_count_t count_i,
    output rx_cfg_t          cfg_o
);

    logic                       req;
    logic                       ack_q;
    logic [`RX_WB_DW-1:0]       rdat;
    logic [`RX_WB_DW-1:0]       rdat_q;
    logic                       prbs_en_q;
    logic                       clr_q;
    logic [`RX_NADC-1:0]        offset_q;
    logic signed [`RX_NADC-1:0] thresh_q;

    // a new request is blocked during the ack cycle so acks never repeat
    assign req = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    always_comb begin
        case (wb_req_i.adr)
            `RX_ADDR_CTRL: begin
                // clear bit is a pulse and reads as zero
                rdat = {{(`RX_WB_DW-2){1'b0}}, 1'b0, prbs_en_q};
            end
            `RX_ADDR_OFFSET: begin
                rdat = {{(`RX_WB_DW-`RX_NADC){1'b0}}, offset_q};
            end
            `RX_ADDR_THRESH: begin
                rdat = {{(`RX_WB_DW-`RX_NADC){1'b0}}, thresh_q};
            end
            `RX_ADDR_ERRCNT: begin
                rdat = count_i.err_count;
            end
            `RX_ADDR_TOTCNT: begin
                rdat = count_i.total_count;
            end
            default: begin
                rdat = '0;
            end
        endcase
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q     <= 1'b0;
            clr_q     <= 1'b0;
            prbs_en_q <= 1'b0;
            offset_q  <= '0;
            thresh_q  <= '0;
        end else begin
            ack_q <= req;
            clr_q <= 1'b0;
            if (req && wb_req_i.we) begin
                case (wb_req_i.adr)
                    `RX_ADDR_CTRL: begin
                        prbs_en_q <= wb_req_i.dat[0];
                        clr_q     <= wb_req_i.dat[1];
                    end
                    `RX_ADDR_OFFSET: begin
                        offset_q <= wb_req_i.dat[`RX_NADC-1:0];
                    end
                    `RX_ADDR_THRESH: begin
                        thresh_q <= wb_req_i.dat[`RX_NADC-1:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read data is captured together with the ack
    always_ff @(posedge clk_adc_i) begin
        if (req) begin
            rdat_q <= rdat;
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};

    assign cfg_o = '{
        prbs_en:    prbs_en_q,
        cnt_clr:    clr_q,
        pfd_offset: offset_q,
        thresh:     thresh_q
    };

endmodule

`default_nettype wire

/* src/rx_digital_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_dsp_macros.svh"

module rx_digital_core import rx_dsp_pkg::*; (
    input  wire logic        clk_adc_i,
    input  wire logic        arst_n_i,
    input  wire adc_word_t   adc_i,
    input  wire logic        adc_valid_i,
    input  wire wb_req_t     wb_req_i,
    output wb_rsp_t          wb_rsp_o,
    output logic [`RX_NTI-1:0] rx_bits_o,
    output logic             rx_bits_valid_o
);

    sample_word_t sample_w;
    bit_word_t    bits_w;
    prbs_count_t  count_w;
    rx_cfg_t      cfg_w;

    // stage 1 turns sign and magnitude into signed samples
    adc_unfold_stage u_unfold (
        .clk_adc_i   (clk_adc_i),
        .arst_n_i    (arst_n_i),
        .adc_i       (adc_i),
        .adc_valid_i (adc_valid_i),
        .cfg_i       (cfg_w),
        .sample_o    (sample_w)
    );

    // stage 2 makes the threshold decision
    slicer_stage u_slicer (
        .clk_adc_i (clk_adc_i),
        .arst_n_i  (arst_n_i),
        .sample_i  (sample_w),
        .cfg_i     (cfg_w),
        .bits_o    (bits_w)
    );

    // stage 3 counts errors and bits
    prbs_check_stage u_prbs_check (
        .clk_adc_i (clk_adc_i),
        .arst_n_i  (arst_n_i),
        .bits_i    (bits_w),
        .cfg_i     (cfg_w),
        .count_o   (count_w)
    );

    rx_csr_wb u_csr (
        .clk_adc_i (clk_adc_i),
        .arst_n_i  (arst_n_i),
        .wb_req_i  (wb_req_i),
        .wb_rsp_o  (wb_rsp_o),
        .count_i   (count_w),
        .cfg_o     (cfg_w)
    );

    assign rx_bits_o       = bits_w.bits;
    assign rx_bits_valid_o = bits_w.valid;

endmodule

`default_nettype wire

/* src/rx_dsp_pkg.sv */
`default_nettype none

`include "rx_dsp_macros.svh"

package rx_dsp_pkg;

    typedef logic signed [`RX_NADC-1:0] sample_t;

    // raw slice outputs, magnitude code plus sign per slice
    typedef struct packed {
        logic [`RX_NTI-1:0][`RX_NADC-1:0] mag;
        logic [`RX_NTI-1:0]               sign;
    } adc_word_t;

    typedef struct packed {
        logic                   valid;
        sample_t [`RX_NTI-1:0]  smp;
    } sample_word_t;

    // bit 0 is the earliest bit in time
    typedef struct packed {
        logic               valid;
        logic [`RX_NTI-1:0] bits;
    } bit_word_t;

    typedef struct packed {
        logic                      prbs_en;
        logic                      cnt_clr;
        logic [`RX_NADC-1:0]       pfd_offset;
        logic signed [`RX_NADC-1:0] thresh;
    } rx_cfg_t;

    typedef struct packed {
        logic [`RX_NCNT-1:0] err_count;
        logic [`RX_NCNT-1:0] total_count;
    } prbs_count_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`RX_WB_AW-1:0] adr;
        logic [`RX_WB_DW-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [`RX_WB_DW-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* src/slicer_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_dsp_macros.svh"

module slicer_stage import rx_dsp_pkg::*; (
    input  wire logic         clk_adc_i,
    input  wire logic         arst_n_i,
    input  wire sample_word_t sample_i,
    input  wire rx_cfg_t      cfg_i,
    output bit_word_t         bits_o
);

    logic [`RX_NTI-1:0] bits_d;
    logic [`RX_NTI-1:0] bits_q;
    logic               valid_q;

    // strictly greater than the signed threshold gives a one
    always_comb begin
        for (int i = 0; i < `RX_NTI; i++) begin
            bits_d[i] = $signed(sample_i.smp[i]) > cfg_i.thresh;
        end
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sample_i.valid;
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (sample_i.valid) begin
            bits_q <= bits_d;
        end
    end

    assign bits_o = '{valid: valid_q, bits: bits_q};

endmodule

`default_nettype wire

/* tests/rx_digital_core_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_digital_core_chk import rx_dsp_pkg::*; (
    input wire logic    clk_i,
    input wire logic    arst_n_i,
    input wire wb_req_t wb_req_i,
    input wire wb_rsp_t wb_rsp_i,
    input wire logic    bits_valid_i
);

    // failure count for the end of run summary
    int unsigned fails = 0;

    // an ack answers a request seen on the edge before
    ack_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
    else begin
        $error("ack without a pending request");
        fails++;
    end

    ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else begin
        $error("ack high on two consecutive cycles");
        fails++;
    end

    valid_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !bits_valid_i)
    else begin
        $error("output valid high during reset");
        fails++;
    end

endmodule

bind rx_digital_core rx_digital_core_chk u_chk (
    .clk_i        (clk_adc_i),
    .arst_n_i     (arst_n_i),
    .wb_req_i     (wb_req_i),
    .wb_rsp_i     (wb_rsp_o),
    .bits_valid_i (rx_bits_valid_o)
);

`default_nettype wire

/* tests/tb_rx_digital_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_dsp_macros.svh"

module tb_rx_digital_core import rx_dsp_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic                 clk_adc;
    logic                 arst_n;
    adc_word_t            adc;
    logic                 adc_valid;
    wb_req_t              wb_req;
    wb_rsp_t              wb_rsp;
    logic [`RX_NTI-1:0]   rx_bits;
    logic                 rx_bits_valid;

    logic [`RX_NTI-1:0]   exp_q[$];
    int                   value_errs = 0;
    int                   proto_errs = 0;
    string                test_name;

    // mirror of the programmed offset and threshold
    logic [`RX_NADC-1:0]        cur_off;
    logic signed [`RX_NADC-1:0] cur_th;
    // expected checker state
    logic [6:0]           m_hist;
    logic                 m_primed;
    logic                 m_en;
    prbs_count_t          m_cnt;
    logic [6:0]           lfsr;

    rx_digital_core u_rx_digital_core (
        .clk_adc_i       (clk_adc),
        .arst_n_i        (arst_n),
        .adc_i           (adc),
        .adc_valid_i     (adc_valid),
        .wb_req_i        (wb_req),
        .wb_rsp_o        (wb_rsp),
        .rx_bits_o       (rx_bits),
        .rx_bits_valid_o (rx_bits_valid)
    );

    initial begin
        clk_adc = 1'b0;
        forever #2 clk_adc = ~clk_adc;
    end

    // unfold, saturate, then slice against the threshold
    function automatic logic [`RX_NTI-1:0] expected_bits(input adc_word_t w,
            input logic [`RX_NADC-1:0] off, input logic signed [`RX_NADC-1:0] th);
        logic [`RX_NTI-1:0] b;
        int s;
        for (int i = 0; i < `RX_NTI; i++) begin
            s = w.sign[i] ? int'(w.mag[i]) - int'(off) : int'(off) - int'(w.mag[i]);
            if (s > 127) s = 127;
            if (s < -128) s = -128;
            b[i] = s > int'(th);
        end
        return b;
    endfunction

    // hist[0] is the newest bit, so hist[6] is n-7 and hist[5] is n-6
    function automatic int count_mismatches(inout logic [6:0] hist,
            input logic [`RX_NTI-1:0] bits);
        int n;
        n = 0;
        for (int i = 0; i < `RX_NTI; i++) begin
            if (bits[i] != (hist[6] ^ hist[5])) n++;
            hist = {hist[5:0], bits[i]};
        end
        return n;
    endfunction

    // next 16 bits of a true PRBS7 sequence
    function automatic logic [`RX_NTI-1:0] next_prbs();
        logic [`RX_NTI-1:0] b;
        for (int i = 0; i < `RX_NTI; i++) begin
            b[i] = lfsr[6] ^ lfsr[5];
            lfsr = {lfsr[5:0], b[i]};
        end
        return b;
    endfunction

    function automatic adc_word_t random_word(input logic corner);
        adc_word_t w;
        for (int i = 0; i < `RX_NTI; i++) begin
            w.mag[i]  = corner ? ($urandom_range(0, 1) ? 8'd255 : 8'd0) : 8'($urandom);
            w.sign[i] = 1'($urandom);
        end
        return w;
    endfunction

    // with zero offset and threshold the sign bit alone decides the bit
    function automatic adc_word_t prbs_word(input logic [`RX_NTI-1:0] bits);
        adc_word_t w;
        for (int i = 0; i < `RX_NTI; i++) begin
            w.mag[i]  = 8'($urandom_range(1, 255));
            w.sign[i] = bits[i];
        end
        return w;
    endfunction

    task automatic compare_bits(input string name, input bit_word_t exp, input bit_word_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic compare_count(input string name, input prbs_count_t exp,
            input prbs_count_t act);
        if (exp !== act) begin
            $display("FAILED %s expected err %0d total %0d actual err %0d total %0d",
                name, exp.err_count, exp.total_count, act.err_count, act.total_count);
            value_errs++;
        end
    endtask

    task automatic compare_reg(input string name, input logic [`RX_WB_DW-1:0] exp,
            input logic [`RX_WB_DW-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic wb_access(input logic we, input logic [`RX_WB_AW-1:0] adr,
            input logic [`RX_WB_DW-1:0] wdat, output logic [`RX_WB_DW-1:0] rdat);
        int t;
        @(negedge clk_adc);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        t = 0;
        do begin
            @(negedge clk_adc);
            t++;
        end while (!wb_rsp.ack && t < TIMEOUT);
        rdat = wb_rsp.dat;
        wb_req = '0;
        if (!wb_rsp.ack) begin
            $display("wishbone access to address %0d was never acknowledged", adr);
            proto_errs++;
        end else begin
            @(negedge clk_adc);
            if (wb_rsp.ack) begin
                $display("ack stayed high for a second cycle at address %0d", adr);
                proto_errs++;
            end
        end
    endtask

    task automatic wb_write(input logic [`RX_WB_AW-1:0] adr, input logic [`RX_WB_DW-1:0] dat);
        logic [`RX_WB_DW-1:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [`RX_WB_AW-1:0] adr, output logic [`RX_WB_DW-1:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    task automatic set_ctrl(input logic [`RX_WB_DW-1:0] v);
        wb_write(`RX_ADDR_CTRL, v);
        m_en = v[0];
        if (v[1]) begin
            m_primed = 1'b0;
            m_cnt    = '0;
        end
    endtask

    task automatic read_counts(output prbs_count_t c);
        wb_read(`RX_ADDR_ERRCNT, c.err_count);
        wb_read(`RX_ADDR_TOTCNT, c.total_count);
    endtask

    task automatic drive_word(input adc_word_t w);
        logic [`RX_NTI-1:0] b;
        int n;
        @(negedge clk_adc);
        adc       = w;
        adc_valid = 1'b1;
        b = expected_bits(w, cur_off, cur_th);
        exp_q.push_back(b);
        n = count_mismatches(m_hist, b);
        if (!m_primed) begin
            m_primed = 1'b1;
        end else if (m_en) begin
            m_cnt.err_count   += n;
            m_cnt.total_count += `RX_NTI;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_adc);
            adc_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < TIMEOUT) begin
            @(posedge clk_adc);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("pipeline never delivered %0d expected words", exp_q.size());
            proto_errs++;
            exp_q.delete();
        end
        repeat (2) @(posedge clk_adc);
    endtask

    // every valid output word is checked in order against the queue
    initial begin : compare_output
        bit_word_t exp_w;
        forever begin
            @(negedge clk_adc);
            if (arst_n && rx_bits_valid) begin
                if (exp_q.size() == 0) begin
                    $display("an output word appeared with no word expected");
                    proto_errs++;
                end else begin
                    exp_w = '{valid: 1'b1, bits: exp_q.pop_front()};
                    compare_bits(test_name, exp_w, '{valid: rx_bits_valid, bits: rx_bits});
                end
            end
        end
    end

    initial begin : main
        logic [`RX_WB_DW-1:0] v;
        logic [`RX_WB_DW-1:0] rd;
        prbs_count_t          got;
        prbs_count_t          held;
        logic [`RX_NTI-1:0]   b;
        int                   nwords;
        int                   total;
        void'($urandom(32'h2256));
        arst_n    = 1'b0;
        adc       = '0;
        adc_valid = 1'b0;
        wb_req    = '0;
        cur_off   = '0;
        cur_th    = '0;
        m_hist    = '0;
        m_primed  = 1'b0;
        m_en      = 1'b0;
        m_cnt     = '0;
        lfsr      = 7'h7f;
        test_name = "reset";
        repeat (16) @(posedge clk_adc);
        @(negedge clk_adc);
        arst_n = 1'b1;

        test_name = "register_access";
        for (int i = 0; i < 8; i++) begin
            v = $urandom;
            wb_write(`RX_ADDR_OFFSET, v);
            wb_read(`RX_ADDR_OFFSET, rd);
            compare_reg(test_name, 32'(v[7:0]), rd);
            wb_write(`RX_ADDR_THRESH, v >> 8);
            wb_read(`RX_ADDR_THRESH, rd);
            compare_reg(test_name, 32'(v[15:8]), rd);
            set_ctrl(v >> 16);
            wb_read(`RX_ADDR_CTRL, rd);
            compare_reg(test_name, 32'(v[16]), rd);
        end
        wb_write(3'd6, $urandom);
        wb_read(3'd6, rd);
        compare_reg(test_name, '0, rd);
        wb_read(3'd7, rd);
        compare_reg(test_name, '0, rd);
        set_ctrl(32'h2);
        // the clear bit written just now reads back as zero
        wb_read(`RX_ADDR_CTRL, rd);
        compare_reg(test_name, '0, rd);

        // first two bursts use large offsets and 0/255 codes
        test_name = "unfold_slice";
        for (int k = 0; k < 6; k++) begin
            v = $urandom;
            cur_off = (k < 2) ? (v[7:0] | 8'hc0) : v[7:0];
            cur_th  = v[15:8];
            wb_write(`RX_ADDR_OFFSET, 32'(cur_off));
            wb_write(`RX_ADDR_THRESH, 32'(v[15:8]));
            nwords = $urandom_range(10, 30);
            for (int j = 0; j < nwords; j++) begin
                drive_word(random_word(k < 2));
                if ($urandom_range(0, 3) == 0) idle(1);
            end
            idle(1);
            wait_drain();
        end

        test_name = "clean_prbs";
        cur_off = '0;
        cur_th  = '0;
        wb_write(`RX_ADDR_OFFSET, '0);
        wb_write(`RX_ADDR_THRESH, '0);
        set_ctrl(32'h3);
        nwords = 40;
        for (int j = 0; j < nwords; j++) begin
            drive_word(prbs_word(next_prbs()));
            if ($urandom_range(0, 2) == 0) idle($urandom_range(1, 3));
        end
        idle(1);
        wait_drain();
        read_counts(got);
        compare_count(test_name, '{err_count: '0, total_count: `RX_NTI * (nwords - 1)}, got);

        test_name = "injected_errors";
        set_ctrl(32'h3);
        for (int j = 0; j < nwords; j++) begin
            b = next_prbs();
            if (j % 5 == 2) b[$urandom_range(0, `RX_NTI - 1)] ^= 1'b1;
            drive_word(prbs_word(b));
            if ($urandom_range(0, 2) == 0) idle(1);
        end
        idle(1);
        wait_drain();
        read_counts(got);
        compare_count(test_name,
            '{err_count: m_cnt.err_count, total_count: `RX_NTI * (nwords - 1)}, got);

        // counts freeze while disabled, then clear to zero
        test_name = "clear_disable";
        set_ctrl(32'h0);
        read_counts(held);
        compare_count(test_name, m_cnt, held);
        for (int j = 0; j < 20; j++) begin
            drive_word(prbs_word(next_prbs()));
        end
        idle(1);
        wait_drain();
        read_counts(got);
        compare_count(test_name, m_cnt, got);
        set_ctrl(32'h2);
        read_counts(got);
        compare_count(test_name, '0, got);

        idle(4);
        total = value_errs + proto_errs + int'(u_rx_digital_core.u_chk.fails);
        $display("errors: %0d value, %0d protocol or timeout, %0d assertion", value_errs,
            proto_errs, u_rx_digital_core.u_chk.fails);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
